/* pi1_dcache.f */
dcache_pkg.sv
dcache_store.sv
dcache_wbuf.sv
dcache_ctrl.sv
pi1_dcache.sv
tb_clock.sv
tb_pi1_dcache.sv

/* Bender.yml */
package:
  name: pi1_dcache

sources:
  - dcache_pkg.sv
  - dcache_store.sv
  - dcache_wbuf.sv
  - dcache_ctrl.sv
  - pi1_dcache.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_pi1_dcache.sv

/* tb_pi1_dcache.sv */
// Directed testbench for the data cache; a memory model answers the slave port with random stalls.
`timescale 1ns/1ps

module tb_pi1_dcache import dcache_pkg::*; ();

	// The six tests need a few hundred cycles even with memory stalls, so this leaves ample margin.
	localparam int CYCLE_LIMIT = 4000;
	localparam int MEM_WORDS = 1 << ADDR_W;

	logic       clk_i;
	logic       rst_i;
	logic       flush_i;
	pi_op_t     m_op_i;
	word_addr_t m_addr_i;
	word_t      m_data_i;
	byte_sel_t  m_sel_i;
	word_t      m_data_o;
	logic       m_rdy_o;
	pi_op_t     s_op_o;
	word_addr_t s_addr_o;
	word_t      s_data_o;
	byte_sel_t  s_sel_o;
	word_t      s_data_i;
	logic       s_rdy_i;

	word_t      mem [MEM_WORDS];
	word_addr_t write_log [$];
	word_t      merged;
	int         slave_reads;
	int         slave_writes;
	int         writes_sent;
	logic       hold_rdy;
	int         seed;
	int         cycle_count;

	tb_clock #(.HALF_PERIOD(50), .RST_CYCLES(8)) u_clock (.clk_o(clk_i), .rst_o(rst_i));

	pi1_dcache uut (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.flush_i  (flush_i),
		.m_op_i   (m_op_i),
		.m_addr_i (m_addr_i),
		.m_data_i (m_data_i),
		.m_sel_i  (m_sel_i),
		.m_data_o (m_data_o),
		.m_rdy_o  (m_rdy_o),
		.s_op_o   (s_op_o),
		.s_addr_o (s_addr_o),
		.s_data_o (s_data_o),
		.s_sel_o  (s_sel_o),
		.s_data_i (s_data_i),
		.s_rdy_i  (s_rdy_i)
	);

	// Each memory word carries its own address twice, once inverted.
	function automatic word_t fill_pattern(input word_addr_t addr);
		return {4'hA, addr, ~addr};
	endfunction

	// The memory model merges the selected bytes on writes and returns read data on a later cycle.
	always @(posedge clk_i) begin
		if (!rst_i && s_rdy_i) begin
			if (s_op_o == PI_WR) begin
				merged = mem[s_addr_o];
				for (int b = 0; b < SEL_W; b++) begin
					if (s_sel_o[b]) begin
						merged[b*8 +: 8] = s_data_o[b*8 +: 8];
					end
				end
				mem[s_addr_o] <= merged;
				write_log.push_back(s_addr_o);
				slave_writes <= slave_writes + 1;
			end else if (s_op_o == PI_RD) begin
				// A miss fetch always asks for the whole word.
				check_value("s_sel_o on fetch", s_sel_o, 4'hF);
				s_data_i <= mem[s_addr_o];
				slave_reads <= slave_reads + 1;
			end
		end
	end

	// Memory stalls on about one cycle in four, and always while hold_rdy is set.
	always @(posedge clk_i) begin
		if (hold_rdy) begin
			s_rdy_i <= 1'b0;
		end else begin
			s_rdy_i <= (($random(seed) & 3) != 0);
		end
	end

	always @(posedge clk_i) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

	task automatic check_value(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("CHECK FAILED: %s is 0x%h, expected 0x%h", name, actual, expected);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	// Presents a request and returns at the edge that accepts it.
	task automatic send_req(input pi_op_t op, input word_addr_t addr, input word_t data,
			input byte_sel_t sel);
		m_op_i <= op;
		m_addr_i <= addr;
		m_data_i <= data;
		m_sel_i <= sel;
		@(posedge clk_i);
		while (!m_rdy_o) begin
			@(posedge clk_i);
		end
	endtask

	task automatic read_word(input word_addr_t addr, input byte_sel_t sel, output word_t data);
		send_req(PI_RD, addr, '0, sel);
		m_op_i <= PI_NOOP;
		@(posedge clk_i);
		while (!m_rdy_o) begin
			@(posedge clk_i);
		end
		data = m_data_o;
	endtask

	task automatic write_word(input word_addr_t addr, input word_t data, input byte_sel_t sel);
		send_req(PI_WR, addr, data, sel);
		m_op_i <= PI_NOOP;
		writes_sent++;
	endtask

	// Waits until memory has taken every write sent so far.
	task automatic wait_drain();
		while (slave_writes != writes_sent) begin
			@(posedge clk_i);
		end
	endtask

	task automatic sweep_after_reset();
		@(posedge clk_i);
		while (rst_i) begin
			@(posedge clk_i);
		end
		check_value("m_rdy_o during sweep", m_rdy_o, 0);
		while (!m_rdy_o) begin
			@(posedge clk_i);
		end
		check_value("s_op_o", s_op_o, PI_NOOP);
	endtask

	task automatic read_miss_then_hit();
		word_t data;
		int reads_before;
		reads_before = slave_reads;
		read_word(14'h0105, 4'hF, data);
		check_value("m_data_o on miss", data, fill_pattern(14'h0105));
		check_value("slave read count", slave_reads, reads_before + 1);
		read_word(14'h0105, 4'hF, data);
		check_value("m_data_o on hit", data, fill_pattern(14'h0105));
		check_value("slave read count", slave_reads, reads_before + 1);
	endtask

	task automatic write_then_read();
		word_t data;
		int reads_before;
		reads_before = slave_reads;
		write_word(14'h0040, 32'hCAFE_0040, 4'hF);
		read_word(14'h0040, 4'hF, data);
		check_value("m_data_o after write", data, 32'hCAFE_0040);
		check_value("slave read count", slave_reads, reads_before);
		wait_drain();
		check_value("memory word 0x0040", mem[14'h0040], 32'hCAFE_0040);
	endtask

	task automatic partial_write_fill();
		word_t data;
		word_t expected;
		int reads_before;
		reads_before = slave_reads;
		write_word(14'h0123, 32'h0000_5A00, 4'b0010);
		read_word(14'h0123, 4'b0010, data);
		check_value("m_data_o byte 1", data[15:8], 8'h5A);
		check_value("slave read count", slave_reads, reads_before);
		// The full word misses, and memory already holds the written byte.
		expected = fill_pattern(14'h0123);
		expected[15:8] = 8'h5A;
		read_word(14'h0123, 4'hF, data);
		check_value("m_data_o full word", data, expected);
		check_value("slave read count", slave_reads, reads_before + 1);
	endtask

	task automatic stalled_write_order();
		int log_start;
		logic stalled;
		word_addr_t base;
		base = 14'h0200;
		stalled = 1'b0;
		wait_drain();
		hold_rdy <= 1'b1;
		repeat (2) @(posedge clk_i);
		log_start = write_log.size();
		for (int i = 0; i < 6; i++) begin
			m_op_i <= PI_WR;
			m_addr_i <= base + word_addr_t'(i);
			m_data_i <= 32'h5100_0000 | i;
			m_sel_i <= '1;
			@(posedge clk_i);
			while (!m_rdy_o) begin
				stalled = 1'b1;
				hold_rdy <= 1'b0;
				@(posedge clk_i);
			end
			writes_sent++;
		end
		m_op_i <= PI_NOOP;
		check_value("m_rdy_o stall seen", stalled, 1);
		wait_drain();
		for (int i = 0; i < 6; i++) begin
			check_value("write order address", write_log[log_start + i], base + i);
			check_value("memory word", mem[base + i], 32'h5100_0000 | i);
		end
	endtask

	task automatic flush_invalidate();
		word_t data;
		int reads_before;
		// The stalled writes took over this set, so the line is brought back first.
		read_word(14'h0105, 4'hF, data);
		reads_before = slave_reads;
		read_word(14'h0105, 4'hF, data);
		check_value("m_data_o before flush", data, fill_pattern(14'h0105));
		check_value("slave read count", slave_reads, reads_before);
		flush_i <= 1'b1;
		@(posedge clk_i);
		flush_i <= 1'b0;
		@(posedge clk_i);
		check_value("m_rdy_o during flush", m_rdy_o, 0);
		while (!m_rdy_o) begin
			@(posedge clk_i);
		end
		read_word(14'h0105, 4'hF, data);
		check_value("m_data_o after flush", data, fill_pattern(14'h0105));
		check_value("slave read count", slave_reads, reads_before + 1);
	endtask

	initial begin
		seed = 59707;
		hold_rdy = 1'b0;
		flush_i = 1'b0;
		m_op_i = PI_NOOP;
		m_addr_i = '0;
		m_data_i = '0;
		m_sel_i = '0;
		s_data_i = '0;
		s_rdy_i = 1'b0;
		slave_reads = 0;
		slave_writes = 0;
		writes_sent = 0;
		cycle_count = 0;
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem[a] = fill_pattern(word_addr_t'(a));
		end
		sweep_after_reset();
		read_miss_then_hit();
		write_then_read();
		partial_write_fill();
		stalled_write_order();
		flush_invalidate();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* tb_clock.sv */
// Clock and reset source for the cache testbench; reset is held high for a set number of cycles.
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_PERIOD = 50,
	parameter int RST_CYCLES = 8
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(HALF_PERIOD) clk_o = ~clk_o;
		end
	end

	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

/* pi1_dcache.sv */
// Top level of the write-through data cache joining the line store, write buffer and controller.
`timescale 1ns/1ps

module pi1_dcache import dcache_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       flush_i,
	input  pi_op_t     m_op_i,
	input  word_addr_t m_addr_i,
	input  word_t      m_data_i,
	input  byte_sel_t  m_sel_i,
	output word_t      m_data_o,
	output logic       m_rdy_o,
	output pi_op_t     s_op_o,
	output word_addr_t s_addr_o,
	output word_t      s_data_o,
	output byte_sel_t  s_sel_o,
	input  word_t      s_data_i,
	input  logic       s_rdy_i
);

	word_addr_t lookup_addr;
	byte_sel_t  lookup_sel;
	logic       store_busy;
	logic       hit;
	word_t      hit_data;
	logic       fill_en;
	word_t      fill_data;
	byte_sel_t  fill_sel;

	logic       push;
	logic       pop;
	logic       head_valid;
	word_addr_t head_addr;
	word_t      head_data;
	byte_sel_t  head_sel;
	logic       almost_full;

	dcache_store u_store (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.flush_i       (flush_i),
		.busy_o        (store_busy),
		.lookup_addr_i (lookup_addr),
		.lookup_sel_i  (lookup_sel),
		.hit_o         (hit),
		.hit_data_o    (hit_data),
		.fill_en_i     (fill_en),
		.fill_data_i   (fill_data),
		.fill_sel_i    (fill_sel)
	);

	// The buffer takes write payloads straight from the CPU port.
	dcache_wbuf u_wbuf (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.push_i        (push),
		.push_addr_i   (m_addr_i),
		.push_data_i   (m_data_i),
		.push_sel_i    (m_sel_i),
		.head_valid_o  (head_valid),
		.head_addr_o   (head_addr),
		.head_data_o   (head_data),
		.head_sel_o    (head_sel),
		.pop_i         (pop),
		.almost_full_o (almost_full)
	);

	dcache_ctrl u_ctrl (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.m_op_i        (m_op_i),
		.m_addr_i      (m_addr_i),
		.m_data_i      (m_data_i),
		.m_sel_i       (m_sel_i),
		.m_data_o      (m_data_o),
		.m_rdy_o       (m_rdy_o),
		.s_op_o        (s_op_o),
		.s_addr_o      (s_addr_o),
		.s_data_o      (s_data_o),
		.s_sel_o       (s_sel_o),
		.s_data_i      (s_data_i),
		.s_rdy_i       (s_rdy_i),
		.lookup_addr_o (lookup_addr),
		.lookup_sel_o  (lookup_sel),
		.fill_en_o     (fill_en),
		.fill_data_o   (fill_data),
		.fill_sel_o    (fill_sel),
		.store_busy_i  (store_busy),
		.hit_i         (hit),
		.hit_data_i    (hit_data),
		.push_o        (push),
		.pop_o         (pop),
		.head_valid_i  (head_valid),
		.head_addr_i   (head_addr),
		.head_data_i   (head_data),
		.head_sel_i    (head_sel),
		.almost_full_i (almost_full)
	);

endmodule

/* dcache_ctrl.sv */
// Cache controller that holds the accepted request, drives both port handshakes and orders fetches.
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	input  pi_op_t     m_op_i,
	input  word_addr_t m_addr_i,
	input  word_t      m_data_i,
	input  byte_sel_t  m_sel_i,
	output word_t      m_data_o,
	output logic       m_rdy_o,
	output pi_op_t     s_op_o,
	output word_addr_t s_addr_o,
	output word_t      s_data_o,
	output byte_sel_t  s_sel_o,
	input  word_t      s_data_i,
	input  logic       s_rdy_i,
	output word_addr_t lookup_addr_o,
	output byte_sel_t  lookup_sel_o,
	output logic       fill_en_o,
	output word_t      fill_data_o,
	output byte_sel_t  fill_sel_o,
	input  logic       store_busy_i,
	input  logic       hit_i,
	input  word_t      hit_data_i,
	output logic       push_o,
	output logic       pop_o,
	input  logic       head_valid_i,
	input  word_addr_t head_addr_i,
	input  word_t      head_data_i,
	input  byte_sel_t  head_sel_i,
	input  logic       almost_full_i
);

	ctrl_state_t state_q;
	ctrl_state_t state_d;

	pi_op_t     req_op_q;
	word_addr_t req_addr_q;
	word_t      req_data_q;
	byte_sel_t  req_sel_q;
	word_t      rdata_q;
	logic       wfull_q;

	logic accept;
	logic lookup_rd;
	logic lookup_wr;
	logic rd_miss;
	logic wbuf_phase;
	logic fetch_done;

	assign lookup_rd = (state_q == ST_LOOKUP) && (req_op_q == PI_RD);
	assign lookup_wr = (state_q == ST_LOOKUP) && (req_op_q == PI_WR);
	assign rd_miss = lookup_rd && !hit_i;
	assign fetch_done = (state_q == ST_WAIT) && s_rdy_i;

	// A new request can be taken while idle or while a lookup hits.
	// A full write buffer blocks all requests until one entry drains.
	assign m_rdy_o = ((state_q == ST_IDLE) || ((state_q == ST_LOOKUP) && !rd_miss)) &&
		!store_busy_i && !wfull_q;

	assign accept = m_rdy_o && (m_op_i != PI_NOOP);

	// Writes enter the buffer at acceptance and reach the line store in the lookup cycle.
	assign push_o = accept && (m_op_i == PI_WR);

	assign lookup_addr_o = req_addr_q;
	assign lookup_sel_o = req_sel_q;

	assign fill_en_o = !store_busy_i && (lookup_wr || fetch_done);
	assign fill_data_o = (state_q == ST_WAIT) ? s_data_i : req_data_q;
	assign fill_sel_o = (state_q == ST_WAIT) ? '1 : req_sel_q;

	assign m_data_o = lookup_rd ? hit_data_i : rdata_q;

	// Buffered writes own the memory port in every state except the fetch.
	assign wbuf_phase = (state_q == ST_IDLE) || (state_q == ST_LOOKUP) || (state_q == ST_DRAIN);
	assign pop_o = wbuf_phase && head_valid_i && s_rdy_i;

	always_comb begin
		if (state_q == ST_FETCH) begin
			s_op_o = PI_RD;
		end else if (wbuf_phase && head_valid_i) begin
			s_op_o = PI_WR;
		end else begin
			s_op_o = PI_NOOP;
		end
	end

	assign s_addr_o = (state_q == ST_FETCH) ? req_addr_q : head_addr_i;
	assign s_data_o = head_data_i;
	assign s_sel_o = (state_q == ST_FETCH) ? '1 : head_sel_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (accept) begin
					state_d = ST_LOOKUP;
				end
			end
			ST_LOOKUP: begin
				if (accept) begin
					state_d = ST_LOOKUP;
				end else if (rd_miss) begin
					state_d = ST_DRAIN;
				end else begin
					state_d = ST_IDLE;
				end
			end
			// The miss fetch waits until memory has seen every earlier write.
			ST_DRAIN: begin
				if (!head_valid_i) begin
					state_d = ST_FETCH;
				end
			end
			ST_FETCH: begin
				if (s_rdy_i) begin
					state_d = ST_WAIT;
				end
			end
			ST_WAIT: begin
				if (s_rdy_i) begin
					state_d = ST_IDLE;
				end
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= ST_IDLE;
			req_op_q <= PI_NOOP;
			wfull_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (accept) begin
				req_op_q <= m_op_i;
			end
			if (pop_o) begin
				wfull_q <= 1'b0;
			end else if (push_o && almost_full_i) begin
				wfull_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			req_addr_q <= m_addr_i;
			req_data_q <= m_data_i;
			req_sel_q <= m_sel_i;
		end
		if (lookup_rd && hit_i) begin
			rdata_q <= hit_data_i;
		end else if (fetch_done) begin
			rdata_q <= s_data_i;
		end
	end

	// A memory request that is not yet taken keeps its operation and address.
	slave_req_stable: assert property (
		@(posedge clk_i) disable iff (rst_i)
		((s_op_o != PI_NOOP) && !s_rdy_i) |=> ($stable(s_op_o) && $stable(s_addr_o))
	);

endmodule

/* dcache_wbuf.sv */
// Posted-write FIFO holding address, data and byte selects of writes on their way to memory.
`timescale 1ns/1ps

module dcache_wbuf import dcache_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       push_i,
	input  word_addr_t push_addr_i,
	input  word_t      push_data_i,
	input  byte_sel_t  push_sel_i,
	output logic       head_valid_o,
	output word_addr_t head_addr_o,
	output word_t      head_data_o,
	output byte_sel_t  head_sel_o,
	input  logic       pop_i,
	output logic       almost_full_o
);

	word_addr_t addr_mem [WBUF_DEPTH];
	word_t      data_mem [WBUF_DEPTH];
	byte_sel_t  sel_mem [WBUF_DEPTH];

	logic [WBUF_PTR_W-1:0] wr_ptr_q;
	logic [WBUF_PTR_W-1:0] rd_ptr_q;
	logic [WBUF_CNT_W-1:0] count_q;

	always_ff @(posedge clk_i) begin
		if (push_i) begin
			addr_mem[wr_ptr_q] <= push_addr_i;
			data_mem[wr_ptr_q] <= push_data_i;
			sel_mem[wr_ptr_q] <= push_sel_i;
		end
	end

	// The depth is a power of two, so the pointers wrap on their own.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop_i) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	assign head_valid_o = (count_q != '0);
	assign head_addr_o = addr_mem[rd_ptr_q];
	assign head_data_o = data_mem[rd_ptr_q];
	assign head_sel_o = sel_mem[rd_ptr_q];

	// Exactly one free slot is left.
	assign almost_full_o = (count_q == WBUF_CNT_W'(WBUF_DEPTH - 1));

	push_when_full: assert property (
		@(posedge clk_i) disable iff (rst_i)
		push_i |-> (count_q != WBUF_CNT_W'(WBUF_DEPTH))
	);

	pop_when_empty: assert property (
		@(posedge clk_i) disable iff (rst_i)
		pop_i |-> (count_q != '0)
	);

endmodule

/* dcache_store.sv */
// Direct-mapped line store with tag, data, valid and byte-mask arrays, hit logic and flush sweep.
`timescale 1ns/1ps

module dcache_store import dcache_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       flush_i,
	output logic       busy_o,
	input  word_addr_t lookup_addr_i,
	input  byte_sel_t  lookup_sel_i,
	output logic       hit_o,
	output word_t      hit_data_o,
	input  logic       fill_en_i,
	input  word_t      fill_data_i,
	input  byte_sel_t  fill_sel_i
);

	tag_t      tag_mem [SET_COUNT];
	word_t     data_mem [SET_COUNT];
	byte_sel_t mask_mem [SET_COUNT];
	logic [SET_COUNT-1:0] valid_q;

	set_idx_t sweep_q;
	logic     busy_q;

	set_idx_t  idx;
	tag_t      tag;
	logic      line_match;
	byte_sel_t new_mask;

	assign idx = lookup_addr_i[INDEX_W-1:0];
	assign tag = lookup_addr_i[ADDR_W-1:INDEX_W];

	// The indexed line belongs to the looked-up address.
	assign line_match = valid_q[idx] && (tag_mem[idx] == tag);

	// A hit needs every requested byte to be present in the line.
	assign hit_o = !busy_q && line_match && ((mask_mem[idx] & lookup_sel_i) == lookup_sel_i);
	assign hit_data_o = data_mem[idx];

	// Bytes already held for the same tag are kept; a new tag starts a fresh mask.
	assign new_mask = line_match ? (mask_mem[idx] | fill_sel_i) : fill_sel_i;

	assign busy_o = busy_q;

	always_ff @(posedge clk_i) begin
		if (fill_en_i) begin
			tag_mem[idx] <= tag;
			mask_mem[idx] <= new_mask;
			for (int b = 0; b < SEL_W; b++) begin
				if (fill_sel_i[b]) begin
					data_mem[idx][b*8 +: 8] <= fill_data_i[b*8 +: 8];
				end
			end
		end
	end

	// The sweep walks from the top set down to set 0, one set per cycle.
	always_ff @(posedge clk_i) begin
		if (rst_i || flush_i) begin
			busy_q <= 1'b1;
			sweep_q <= set_idx_t'(SET_COUNT - 1);
		end else if (busy_q) begin
			valid_q[sweep_q] <= 1'b0;
			if (sweep_q == '0) begin
				busy_q <= 1'b0;
			end else begin
				sweep_q <= sweep_q - 1'b1;
			end
		end else if (fill_en_i) begin
			valid_q[idx] <= 1'b1;
		end
	end

	// The controller must hold its fills back until the sweep is over.
	fill_while_busy: assert property (
		@(posedge clk_i) disable iff (rst_i)
		fill_en_i |-> !busy_o
	);

endmodule

/* dcache_pkg.sv */
// Shared widths, sizes, port operation codes and controller states, imported by every cache file.
package dcache_pkg;

	// Data word and byte-select widths.
	localparam int ARCH_W = 32;
	localparam int SEL_W = ARCH_W / 8;

	// Word address split into tag and set index.
	localparam int ADDR_W = 14;
	localparam int SET_COUNT = 16;
	localparam int INDEX_W = 4;
	localparam int TAG_W = ADDR_W - INDEX_W;

	// Posted-write buffer geometry.
	localparam int WBUF_DEPTH = 4;
	localparam int WBUF_CNT_W = 3;
	localparam int WBUF_PTR_W = 2;

	typedef logic [ARCH_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] word_addr_t;
	typedef logic [SEL_W-1:0] byte_sel_t;
	typedef logic [INDEX_W-1:0] set_idx_t;
	typedef logic [TAG_W-1:0] tag_t;

	// Operation code shared by the CPU side and the memory side.
	// The code 2'b11 is not used by this cache.
	typedef enum logic [1:0] {
		PI_NOOP = 2'b00,
		PI_WR   = 2'b01,
		PI_RD   = 2'b10
	} pi_op_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_DRAIN,
		ST_FETCH,
		ST_WAIT
	} ctrl_state_t;

endpackage
